// File: bench/posted_tlp_assert.sv
`timescale 1ns/1ps

module posted_tlp_assert import tlp_pkg::*; (
  input logic      clk,
  input logic      rst_reg,
  input logic      desc_req,
  input logic      desc_ack,
  input hdr_word_t tlp_data,
  input logic      tlp_valid,
  input logic      tlp_sop,
  input logic      tlp_eop,
  input logic      tlp_ready,
  input logic      req_go,
  input logic      req_ack,
  input logic      header_data_wren,
  input fifo_cnt_t fifo_count
);

  ack_needs_req: assert property (@(posedge clk) disable iff (rst_reg)
    $rose(desc_ack) |-> desc_req)
    else $error("desc_ack rose while desc_req was low");

  // Word and marks frozen while the sink stalls
  stream_hold: assert property (@(posedge clk) disable iff (rst_reg)
    (tlp_valid && !tlp_ready) |=>
      (tlp_valid && $stable(tlp_data) && $stable(tlp_sop) && $stable(tlp_eop)))
    else $error("Output stream changed under back-pressure");

  // go drops on the edge that sees ack
  ack_one_cycle: assert property (@(posedge clk) disable iff (rst_reg)
    req_ack |=> (!req_ack && !req_go))
    else $error("Builder ack lasted more than one cycle or go stayed high after it");

  no_write_when_full: assert property (@(posedge clk) disable iff (rst_reg)
    header_data_wren |-> (fifo_count != fifo_cnt_t'(HDR_FIFO_DEPTH)))
    else $error("Header write while the FIFO had no free slot");

endmodule

bind posted_tlp_top posted_tlp_assert i_assert (
  .clk              (clk),
  .rst_reg          (rst_reg),
  .desc_req         (desc_req),
  .desc_ack         (desc_ack),
  .tlp_data         (tlp_data),
  .tlp_valid        (tlp_valid),
  .tlp_sop          (tlp_sop),
  .tlp_eop          (tlp_eop),
  .tlp_ready        (tlp_ready),
  .req_go           (req_bus.go),
  .req_ack          (req_bus.ack),
  .header_data_wren (header_data_wren),
  .fifo_count       (i_fifo.count)
);

// File: bench/posted_tlp_tb.sv
`timescale 1ns/1ps

module posted_tlp_tb import tlp_pkg::*; ();

  localparam int RESET_CYCLES     = 4;
  localparam int NUM_DIRECTED     = 5;
  localparam int NUM_RANDOM       = 40;
  localparam int NUM_DESC         = NUM_DIRECTED + NUM_RANDOM;
  localparam int MAX_DESC_LEN     = 200;
  localparam int CYCLES_PER_CHUNK = 40;
  localparam int CYCLES_PER_DESC  =
    ((MAX_DESC_LEN + MAX_PAYLOAD_DW - 1) / MAX_PAYLOAD_DW + 2) * CYCLES_PER_CHUNK;
  localparam int READY_PCT        = 25;  // Low enough to fill the header FIFO

  logic        clk = 1'b0;
  logic        rst_reg;
  logic        desc_req;
  addr_t       desc_addr;
  desc_len_t   desc_len;
  req_id_t     desc_req_id;
  logic        desc_ack;
  hdr_word_t   tlp_data;
  logic        tlp_valid;
  logic        tlp_sop;
  logic        tlp_eop;
  logic        tlp_ready = 1'b1;
  logic        random_ready = 1'b0;

  hdr_word_t   exp_data [$];
  logic        exp_sop [$];
  logic        exp_eop [$];
  int          error_count = 0;
  int          check_count = 0;
  int          word_count = 0;

  posted_tlp_top i_dut (
    .clk         (clk),
    .rst_reg     (rst_reg),
    .desc_req    (desc_req),
    .desc_addr   (desc_addr),
    .desc_len    (desc_len),
    .desc_req_id (desc_req_id),
    .desc_ack    (desc_ack),
    .tlp_data    (tlp_data),
    .tlp_valid   (tlp_valid),
    .tlp_sop     (tlp_sop),
    .tlp_eop     (tlp_eop),
    .tlp_ready   (tlp_ready)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  // Header pair of one chunk with the first word in the upper half
  function automatic logic [127:0] expected_headers(addr_t addr, dw_len_t len, req_id_t id);
    hdr_word_t w0;
    hdr_word_t w1;
    logic      above_4g;
    above_4g  = (addr[63:32] != 32'h0);
    w0        = '0;
    w0[62:61] = above_4g ? FMT_4DW_DATA : FMT_3DW_DATA;
    w0[60:56] = TYPE_MWR;
    w0[41:32] = len;
    w0[31:16] = id;
    w0[7:4]   = BE_ALL;
    w0[3:0]   = BE_ALL;
    if (above_4g)
      w1 = {addr[63:2], 2'b00};
    else
      w1 = {addr[31:2], 2'b00, 32'h0};  // 3DW keeps the address in the upper half
    return {w0, w1};
  endfunction

  task automatic queue_descriptor(input addr_t addr, input desc_len_t len, input req_id_t id);
    addr_t        chunk_addr;
    int           left;
    int           this_len;
    logic [127:0] pair;
    chunk_addr = addr;
    left       = int'(len);
    while (left > 0) begin
      this_len = (left > MAX_PAYLOAD_DW) ? MAX_PAYLOAD_DW : left;
      pair     = expected_headers(chunk_addr, dw_len_t'(this_len), id);
      exp_data.push_back(pair[127:64]);
      exp_sop.push_back(1'b1);
      exp_eop.push_back(1'b0);
      exp_data.push_back(pair[63:0]);
      exp_sop.push_back(1'b0);
      exp_eop.push_back(1'b1);
      chunk_addr = chunk_addr + addr_t'(this_len * 4);
      left       = left - this_len;
    end
  endtask

  task automatic send_descriptor(input addr_t addr, input desc_len_t len, input req_id_t id);
    queue_descriptor(addr, len, id);
    @(posedge clk);
    check_count++;
    assert (desc_ack == 1'b0) else begin
      $display("CHECK FAILED at %0t: descriptor ack still high before a new request", $time);
      error_count++;
    end
    desc_addr   <= addr;
    desc_len    <= len;
    desc_req_id <= id;
    desc_req    <= 1'b1;
    do @(posedge clk); while (!desc_ack);
    desc_req <= 1'b0;
    do @(posedge clk); while (desc_ack);
  endtask

  // All words of the descriptor must be out once the path is empty
  task automatic wait_drain();
    do @(posedge clk); while (!(i_dut.fifo_empty && !tlp_valid));
    check_count++;
    assert (exp_data.size() == 0) else begin
      $display("%0d expected header words never arrived, at %0t", exp_data.size(), $time);
      error_count++;
      exp_data.delete();
      exp_sop.delete();
      exp_eop.delete();
    end
  endtask

  always @(posedge clk) begin
    if (rst_reg || !random_ready)
      tlp_ready <= 1'b1;
    else
      tlp_ready <= (($urandom % 100) < READY_PCT);
  end

  always @(posedge clk) begin : compare_output
    hdr_word_t e_data;
    logic      e_sop;
    logic      e_eop;
    if (!rst_reg && tlp_valid && tlp_ready) begin
      word_count++;
      assert (exp_data.size() > 0) else begin
        $display("Unexpected output word %h at %0t", tlp_data, $time);
        error_count++;
      end
      if (exp_data.size() > 0) begin
        e_data = exp_data.pop_front();
        e_sop  = exp_sop.pop_front();
        e_eop  = exp_eop.pop_front();
        check_count++;
        assert (tlp_data == e_data) else begin
          $display("CHECK FAILED at %0t: data %h, expected %h", $time, tlp_data, e_data);
          error_count++;
        end
        assert (tlp_sop == e_sop && tlp_eop == e_eop) else begin
          $display("CHECK FAILED at %0t: sop/eop %b%b, expected %b%b",
                   $time, tlp_sop, tlp_eop, e_sop, e_eop);
          error_count++;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (RESET_CYCLES + NUM_DESC * CYCLES_PER_DESC) @(posedge clk);
    $display("Watchdog expired, the run did not finish in time");
    $display("Test failures found");
    $finish;
  end

  initial begin : stimulus
    addr_t     r_addr;
    desc_len_t r_len;
    req_id_t   r_id;
    int        words_before;
    void'($urandom(41021));
    rst_reg     <= 1'b1;
    desc_req    <= 1'b0;
    desc_addr   <= '0;
    desc_len    <= '0;
    desc_req_id <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    check_count++;
    assert (!desc_ack && !tlp_valid && !tlp_sop && !tlp_eop) else begin
      $display("CHECK FAILED at %0t: outputs not low in reset, ack %b valid %b sop %b eop %b",
               $time, desc_ack, tlp_valid, tlp_sop, tlp_eop);
      error_count++;
    end
    rst_reg <= 1'b0;

    send_descriptor(64'h0000_0000_8000_1002, 12'd8, 16'h0100);  // Low bits dropped
    wait_drain();
    send_descriptor(64'h0000_0012_3456_7800, 12'd16, 16'hbeef);
    wait_drain();
    send_descriptor(64'h0000_0000_0010_0000, 12'd100, 16'h0a0b);
    wait_drain();
    send_descriptor(64'h0000_0000_ffff_ff80, 12'd70, 16'h1234);  // Crosses 4 GB
    wait_drain();
    words_before = word_count;
    send_descriptor(64'h0000_0000_0000_4000, 12'd0, 16'h0042);
    repeat (10) @(posedge clk);
    check_count++;
    assert (word_count == words_before) else begin
      $display("Zero-length descriptor produced output words at %0t", $time);
      error_count++;
    end

    random_ready <= 1'b1;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r_addr = {$urandom, $urandom};
      if ($urandom % 2 == 0)
        r_addr[63:32] = 32'h0;
      r_len = desc_len_t'($urandom % (MAX_DESC_LEN + 1));
      r_id  = req_id_t'($urandom);
      send_descriptor(r_addr, r_len, r_id);
      wait_drain();
    end
    random_ready <= 1'b0;
    repeat (5) @(posedge clk);

    $display("Summary: %0d checks, %0d errors, %0d words received",
             check_count, error_count, word_count);
    if (error_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: design/dma_write_sequencer.sv
`timescale 1ns/1ps

module dma_write_sequencer import tlp_pkg::*; (
  input  logic            clk,
  input  logic            rst_reg,
  input  logic            desc_req,
  input  addr_t           desc_addr,
  input  desc_len_t       desc_len,
  input  req_id_t         desc_req_id,
  output logic            desc_ack,
  posted_req_if.sequencer req
);

  seq_state_t state;
  addr_t      next_addr;  // Address of the next chunk
  desc_len_t  remaining;  // Doublewords still to issue
  dw_len_t    chunk_len;

  assign chunk_len = (remaining > desc_len_t'(MAX_PAYLOAD_DW)) ?
                     dw_len_t'(MAX_PAYLOAD_DW) : dw_len_t'(remaining);

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      state    <= WAIT_REQ;
      desc_ack <= 1'b0;
      req.go   <= 1'b0;
    end else begin
      case (state)
        WAIT_REQ: begin
          if (desc_req)
            state <= NEXT;  // Zero length falls straight through to the ack
        end
        ISSUE: begin
          req.go <= 1'b1;
          state  <= WAIT_ACK;
        end
        WAIT_ACK: begin
          if (req.ack) begin
            req.go <= 1'b0;
            state  <= NEXT;
          end
        end
        NEXT: begin
          if (remaining == '0) begin
            desc_ack <= 1'b1;
            state    <= HOLD_ACK;
          end else begin
            state <= ISSUE;
          end
        end
        HOLD_ACK: begin
          if (!desc_req) begin
            desc_ack <= 1'b0;
            state    <= WAIT_REQ;
          end
        end
        default: state <= WAIT_REQ;
      endcase
    end
  end

  // Descriptor fields and chunk bookkeeping
  always_ff @(posedge clk) begin
    if (state == WAIT_REQ && desc_req) begin
      next_addr  <= desc_addr;
      remaining  <= desc_len;
      req.req_id <= desc_req_id;
    end else if (state == WAIT_ACK && req.ack) begin
      next_addr <= next_addr + addr_t'({req.length, 2'b00});  // 4 bytes per DW
      remaining <= remaining - desc_len_t'(req.length);
    end
    if (state == ISSUE) begin
      req.dmawad <= next_addr;
      req.length <= chunk_len;
    end
  end

endmodule

// File: design/posted_header_fifo.sv
`timescale 1ns/1ps

module posted_header_fifo import tlp_pkg::*; (
  input  logic      clk,
  input  logic      rst_reg,
  input  hdr_word_t wr_data,
  input  logic      wr_en,
  input  logic      rd_en,
  output hdr_word_t rd_data,
  output logic      empty,
  output logic      posted_fifo_full
);

  hdr_word_t mem [HDR_FIFO_DEPTH];
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  fifo_cnt_t count;
  logic      do_wr;
  logic      do_rd;

  assign do_wr = wr_en && (count != fifo_cnt_t'(HDR_FIFO_DEPTH));
  assign do_rd = rd_en && !empty;

  assign empty   = (count == '0);
  assign rd_data = mem[rd_ptr];  // Show-ahead

  // Fewer than two free slots, so a whole header always fits
  assign posted_fifo_full = (count > fifo_cnt_t'(HDR_FIFO_DEPTH - 2));

  always_ff @(posedge clk) begin
    if (do_wr)
      mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: design/posted_pkt_builder.sv
`timescale 1ns/1ps

module posted_pkt_builder import tlp_pkg::*; (
  input  logic          clk,
  input  logic          rst_reg,
  input  logic          posted_fifo_full,
  posted_req_if.builder req,
  output hdr_word_t     header_data_out,
  output logic          header_data_wren
);

  builder_state_t state;
  addr_t          addr_reg;
  dw_len_t        len_reg;
  req_id_t        id_reg;
  logic [1:0]     fmt;
  hdr_word_t      first_word;
  hdr_word_t      second_word;

  // 4DW header only when the address is above 4 GB
  assign fmt = (addr_reg[63:32] == '0) ? FMT_3DW_DATA : FMT_4DW_DATA;

  assign first_word = {1'b0, fmt, TYPE_MWR,
                       1'b0, 3'b000, 4'b0000,  // Traffic class and reserved bits
                       1'b0, 1'b0, 2'b00,      // TD, EP, attributes
                       2'b00, len_reg,
                       id_reg, 8'h00,          // Tag is always zero
                       BE_ALL, BE_ALL};

  assign second_word = (fmt == FMT_4DW_DATA) ?
                       {addr_reg[63:2], 2'b00} :
                       {addr_reg[31:2], 2'b00, addr_reg[63:32]};

  always_ff @(posedge clk) begin
    if (state == IDLE && req.go) begin
      addr_reg <= req.dmawad;
      len_reg  <= req.length;
      id_reg   <= req.req_id;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      state            <= IDLE;
      header_data_wren <= 1'b0;
      req.ack          <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          header_data_wren <= 1'b0;
          req.ack          <= 1'b0;
          if (req.go && !posted_fifo_full)  // Room for both words is guaranteed here
            state <= HEAD1;
        end
        HEAD1: begin
          header_data_wren <= 1'b1;
          state            <= HEAD2;
        end
        HEAD2: begin
          header_data_wren <= 1'b1;
          req.ack          <= 1'b1;
          state            <= WAIT_FOR_GO_DEASSERT;
        end
        WAIT_FOR_GO_DEASSERT: begin
          header_data_wren <= 1'b0;
          req.ack          <= 1'b0;
          state            <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == HEAD1)
      header_data_out <= first_word;
    else if (state == HEAD2)
      header_data_out <= second_word;
  end

endmodule

// File: design/posted_req_if.sv
`timescale 1ns/1ps

// One chunk request, go held until a single-cycle ack
interface posted_req_if import tlp_pkg::*; ();

  logic    go;
  logic    ack;
  addr_t   dmawad;
  dw_len_t length;
  req_id_t req_id;

  modport sequencer (
    output go, dmawad, length, req_id,
    input  ack
  );

  modport builder (
    input  go, dmawad, length, req_id,
    output ack
  );

endinterface

// File: design/posted_tlp_top.sv
`timescale 1ns/1ps

module posted_tlp_top import tlp_pkg::*; (
  input  logic      clk,
  input  logic      rst_reg,
  input  logic      desc_req,
  input  addr_t     desc_addr,
  input  desc_len_t desc_len,
  input  req_id_t   desc_req_id,
  output logic      desc_ack,
  output hdr_word_t tlp_data,
  output logic      tlp_valid,
  output logic      tlp_sop,
  output logic      tlp_eop,
  input  logic      tlp_ready
);

  hdr_word_t header_data_out;
  logic      header_data_wren;
  logic      posted_fifo_full;
  hdr_word_t fifo_rd_data;
  logic      fifo_empty;
  logic      fifo_rd_en;

  posted_req_if req_bus ();

  dma_write_sequencer i_seq (
    .clk         (clk),
    .rst_reg     (rst_reg),
    .desc_req    (desc_req),
    .desc_addr   (desc_addr),
    .desc_len    (desc_len),
    .desc_req_id (desc_req_id),
    .desc_ack    (desc_ack),
    .req         (req_bus.sequencer)
  );

  posted_pkt_builder i_builder (
    .clk              (clk),
    .rst_reg          (rst_reg),
    .posted_fifo_full (posted_fifo_full),
    .req              (req_bus.builder),
    .header_data_out  (header_data_out),
    .header_data_wren (header_data_wren)
  );

  posted_header_fifo i_fifo (
    .clk              (clk),
    .rst_reg          (rst_reg),
    .wr_data          (header_data_out),
    .wr_en            (header_data_wren),
    .rd_en            (fifo_rd_en),
    .rd_data          (fifo_rd_data),
    .empty            (fifo_empty),
    .posted_fifo_full (posted_fifo_full)
  );

  tlp_header_tx i_tx (
    .clk       (clk),
    .rst_reg   (rst_reg),
    .rd_data   (fifo_rd_data),
    .empty     (fifo_empty),
    .tlp_ready (tlp_ready),
    .rd_en     (fifo_rd_en),
    .tlp_data  (tlp_data),
    .tlp_valid (tlp_valid),
    .tlp_sop   (tlp_sop),
    .tlp_eop   (tlp_eop)
  );

endmodule

// File: design/tlp_header_tx.sv
`timescale 1ns/1ps

module tlp_header_tx import tlp_pkg::*; (
  input  logic      clk,
  input  logic      rst_reg,
  input  hdr_word_t rd_data,
  input  logic      empty,
  input  logic      tlp_ready,
  output logic      rd_en,
  output hdr_word_t tlp_data,
  output logic      tlp_valid,
  output logic      tlp_sop,
  output logic      tlp_eop
);

  logic second_word;  // Next loaded word closes a header

  // Load when the output register is free or drains this cycle
  assign rd_en = !empty && (!tlp_valid || tlp_ready);

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      tlp_valid   <= 1'b0;
      tlp_sop     <= 1'b0;
      tlp_eop     <= 1'b0;
      second_word <= 1'b0;
    end else if (rd_en) begin
      tlp_valid   <= 1'b1;
      tlp_sop     <= !second_word;
      tlp_eop     <= second_word;
      second_word <= !second_word;
    end else if (tlp_ready) begin
      tlp_valid <= 1'b0;
      tlp_sop   <= 1'b0;
      tlp_eop   <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en)
      tlp_data <= rd_data;
  end

endmodule

// File: design/tlp_pkg.sv
package tlp_pkg;

  localparam int ADDR_W      = 64;
  localparam int REQ_ID_W    = 16;
  localparam int DW_LEN_W    = 10;
  localparam int DESC_LEN_W  = 12;
  localparam int HDR_W       = 64;

  localparam int MAX_PAYLOAD_DW = 32;  // Max payload size in doublewords
  localparam int HDR_FIFO_DEPTH = 8;   // Power of two, pointers wrap naturally
  localparam int FIFO_PTR_W     = $clog2(HDR_FIFO_DEPTH);
  localparam int FIFO_CNT_W     = $clog2(HDR_FIFO_DEPTH + 1);

  // Header field codes
  localparam logic [1:0] FMT_3DW_DATA = 2'b10;
  localparam logic [1:0] FMT_4DW_DATA = 2'b11;
  localparam logic [4:0] TYPE_MWR     = 5'b00000;
  localparam logic [3:0] BE_ALL       = 4'b1111;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [REQ_ID_W-1:0]   req_id_t;
  typedef logic [DW_LEN_W-1:0]   dw_len_t;
  typedef logic [DESC_LEN_W-1:0] desc_len_t;
  typedef logic [HDR_W-1:0]      hdr_word_t;
  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

  typedef enum logic [1:0] {
    IDLE,
    HEAD1,
    HEAD2,
    WAIT_FOR_GO_DEASSERT
  } builder_state_t;

  typedef enum logic [2:0] {
    WAIT_REQ,
    ISSUE,
    WAIT_ACK,
    NEXT,
    HOLD_ACK
  } seq_state_t;

endpackage

// File: posted_tlp.f
design/tlp_pkg.sv
design/posted_req_if.sv
design/dma_write_sequencer.sv
design/posted_pkt_builder.sv
design/posted_header_fifo.sv
design/tlp_header_tx.sv
design/posted_tlp_top.sv
bench/posted_tlp_assert.sv
bench/posted_tlp_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the posted write header testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module posted_tlp_tb -f posted_tlp.f -o posted_tlp_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/posted_tlp_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
